// ==== Makefile ====
# Verilator build of the SECDED memory testbench.

OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module ecc_mem_tb --Mdir $(OBJ) -o ecc_mem_sim -f ecc_mem.f

# A failing testbench stops with $fatal, so the binary returns a failing status.
run: compile
	./$(OBJ)/ecc_mem_sim

clean:
	rm -rf $(OBJ)

// ==== ecc_mem.f ====
source/ecc_pkg.sv
source/ecc_78_cal.sv
source/ecc_sram.sv
source/ecc_apb_ctrl.sv
source/ecc_mem_top.sv
verif/ecc_mem_tb.sv

// ==== source/ecc_78_cal.sv ====
`timescale 1ns/100ps

module ecc_78_cal import ecc_pkg::*; (
    input  logic [ECC_DATA_W-1:0] data_in,
    input  logic [ECC_CHK_W-1:0]  parity_in,
    input  logic                  bypass,
    output logic [ECC_DATA_W-1:0] data_out,
    output logic [ECC_CHK_W-1:0]  parity_out,
    output logic [ECC_DATA_W-1:0] mask,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    // H matrix, one column per data bit.
    // Bits 6:0 hold a non-power-of-two Hamming position, bit 7 makes every column odd weight.
    localparam logic [ECC_CHK_W-1:0] H_COL [ECC_DATA_W] = '{
        8'h83, 8'h85, 8'h86, 8'h07, 8'h89, 8'h8A,  // 0
        8'h0B, 8'h8C, 8'h0D, 8'h0E, 8'h8F, 8'h91,
        8'h92, 8'h13, 8'h94, 8'h15, 8'h16, 8'h97,  // 12
        8'h98, 8'h19, 8'h1A, 8'h9B, 8'h1C, 8'h9D,
        8'h9E, 8'h1F, 8'hA1, 8'hA2, 8'h23, 8'hA4,  // 24
        8'h25, 8'h26, 8'hA7, 8'hA8, 8'h29, 8'h2A,
        8'hAB, 8'h2C, 8'hAD, 8'hAE, 8'h2F, 8'hB0,  // 36
        8'h31, 8'h32, 8'hB3, 8'h34, 8'hB5, 8'hB6,
        8'h37, 8'h38, 8'hB9, 8'hBA, 8'h3B, 8'hBC,  // 48
        8'h3D, 8'h3E, 8'hBF, 8'hC1, 8'hC2, 8'h43,
        8'hC4, 8'h45, 8'h46, 8'hC7, 8'hC8, 8'h49,  // 60
        8'h4A, 8'hCB, 8'h4C, 8'hCD, 8'hCE, 8'h4F,
        8'hD0, 8'h51, 8'h52, 8'hD3, 8'h54, 8'hD5   // 72
    };

    logic [ECC_CHK_W-1:0] syndrome;
    logic                 hit_data;  // Syndrome names a data bit.
    logic                 hit_chk;   // Syndrome names a check bit.

    // Encoder.
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (data_in[i]) begin
                parity_out = parity_out ^ H_COL[i];
            end
        end
    end

    assign syndrome = parity_in ^ parity_out;

    // One-hot correction mask; at most one column can match.
    always_comb begin
        for (int i = 0; i < ECC_DATA_W; i++) begin
            mask[i] = (syndrome == H_COL[i]);
        end
    end

    assign hit_data = |mask;
    assign hit_chk  = $onehot(syndrome);

    assign data_out = bypass ? data_in : (data_in ^ mask);

    // Any other nonzero syndrome is treated as uncorrectable.
    assign sbit_err = ~bypass & (hit_data | hit_chk);
    assign dbit_err = ~bypass & (syndrome != '0) & ~hit_data & ~hit_chk;

endmodule

// ==== source/ecc_apb_ctrl.sv ====
`timescale 1ns/100ps

module ecc_apb_ctrl import ecc_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  apb_req_t                 apb_req,
    output apb_rsp_t                 apb_rsp,
    output logic [ECC_DATA_W-1:0]    ecc_data_in,
    output logic [ECC_CHK_W-1:0]     ecc_parity_in,
    output logic                     ecc_bypass,
    input  ecc_res_t                 ecc_res,
    input  logic [ECC_CHK_W-1:0]     ecc_parity_out,
    output logic                     mem_en,
    output logic                     mem_we,
    output logic [$clog2(DEPTH)-1:0] mem_addr,
    output ecc_cw_t                  mem_wdata,
    input  ecc_cw_t                  mem_rdata
);

    localparam int AW = $clog2(DEPTH);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_CAPTURE
    } state_t;

    state_t                state;
    logic                  cmd_rd_q;  // Command in flight is a read.

    logic                  bypass_q;
    logic [APB_DW-1:0]     addr_q;
    logic [ECC_DATA_W-1:0] wdata_q;
    logic [ECC_DATA_W-1:0] rdata_q;
    logic                  sbit_q;
    logic                  dbit_q;
    logic [INJ_POS_W-1:0]  err_pos_q;
    logic [CNT_W-1:0]      sbe_cnt_q;
    logic [CNT_W-1:0]      dbe_cnt_q;
    ecc_inj_t              inj_q;

    logic                  access;
    logic                  pready;
    logic                  mapped;
    logic                  cmd_valid;
    logic                  cmd_bad;
    logic                  cmd_start;
    logic                  reg_wr;
    logic                  capture;
    logic [APB_DW-1:0]     prdata;
    logic [ECC_CW_W-1:0]   flip;      // Indexed by injection position.
    logic [INJ_POS_W-1:0]  mask_pos;

    // Bus decode.
    assign access    = apb_req.psel & apb_req.penable;
    assign pready    = access & (state == ST_IDLE);
    assign cmd_valid = ((apb_req.pwdata == CMD_WRITE) || (apb_req.pwdata == CMD_READ)) &&
                       (addr_q < APB_DW'(DEPTH));
    assign cmd_bad   = apb_req.pwrite & (apb_req.paddr == REG_CMD) & ~cmd_valid;
    assign reg_wr    = pready & apb_req.pwrite & mapped;
    assign capture   = (state == ST_CAPTURE) & cmd_rd_q;

    // Started in the setup phase, so the array is driven in the first access cycle.
    assign cmd_start = apb_req.psel & ~apb_req.penable & apb_req.pwrite &
                       (apb_req.paddr == REG_CMD) & cmd_valid & (state == ST_IDLE);

    assign apb_rsp = '{prdata:  prdata,
                       pready:  pready,
                       pslverr: pready & (~mapped | cmd_bad)};

    always_comb begin
        prdata = '0;
        mapped = 1'b1;
        case (apb_req.paddr)
            REG_CTRL:    prdata = APB_DW'(bypass_q);
            REG_ADDR:    prdata = addr_q;
            REG_WDATA0:  prdata = wdata_q[31:0];
            REG_WDATA1:  prdata = wdata_q[63:32];
            REG_WDATA2:  prdata = APB_DW'(wdata_q[ECC_DATA_W-1:64]);
            REG_CMD:     prdata = '0;  // Write only.
            REG_RDATA0:  prdata = rdata_q[31:0];
            REG_RDATA1:  prdata = rdata_q[63:32];
            REG_RDATA2:  prdata = APB_DW'(rdata_q[ECC_DATA_W-1:64]);
            REG_STATUS:  prdata = APB_DW'({dbit_q, sbit_q});
            REG_ERR_POS: prdata = APB_DW'(err_pos_q);
            REG_SBE_CNT: prdata = APB_DW'(sbe_cnt_q);
            REG_DBE_CNT: prdata = APB_DW'(dbe_cnt_q);
            REG_INJ:     prdata = APB_DW'(inj_q);
            default:     mapped = 1'b0;
        endcase
    end

    // Command sequencer.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            cmd_rd_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_start) begin
                        state    <= ST_ISSUE;
                        cmd_rd_q <= (apb_req.pwdata == CMD_READ);
                    end
                end
                ST_ISSUE:   state <= ST_CAPTURE;  // Array write or read at this edge.
                ST_CAPTURE: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Register file, error log and counters.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bypass_q  <= 1'b0;
            addr_q    <= '0;
            wdata_q   <= '0;
            rdata_q   <= '0;
            sbit_q    <= 1'b0;
            dbit_q    <= 1'b0;
            err_pos_q <= '0;
            sbe_cnt_q <= '0;
            dbe_cnt_q <= '0;
            inj_q     <= '0;
        end else begin
            if (reg_wr) begin
                case (apb_req.paddr)
                    REG_CTRL:    bypass_q <= apb_req.pwdata[0];
                    REG_ADDR:    addr_q <= apb_req.pwdata;
                    REG_WDATA0:  wdata_q[31:0] <= apb_req.pwdata;
                    REG_WDATA1:  wdata_q[63:32] <= apb_req.pwdata;
                    REG_WDATA2:  wdata_q[ECC_DATA_W-1:64] <= apb_req.pwdata[ECC_DATA_W-65:0];
                    REG_SBE_CNT: sbe_cnt_q <= '0;
                    REG_DBE_CNT: dbe_cnt_q <= '0;
                    REG_INJ:     inj_q <= ecc_inj_t'(apb_req.pwdata[$bits(ecc_inj_t)-1:0]);
                    default:     ;
                endcase
            end
            // One-shot; consumed by the write it was armed for.
            if ((state == ST_ISSUE) && !cmd_rd_q) begin
                inj_q <= '0;
            end
            if (capture) begin
                rdata_q <= ecc_res.data;
                sbit_q  <= ecc_res.sbit_err;
                dbit_q  <= ecc_res.dbit_err;
                if (ecc_res.sbit_err) begin
                    err_pos_q <= mask_pos;
                end
                if (ecc_res.sbit_err && (sbe_cnt_q != '1)) begin
                    sbe_cnt_q <= sbe_cnt_q + 1'b1;
                end
                if (ecc_res.dbit_err && (dbe_cnt_q != '1)) begin
                    dbe_cnt_q <= dbe_cnt_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ECC_CW_W; i++) begin
            flip[i] = (inj_q.en0 && (inj_q.pos0 == i)) || (inj_q.en1 && (inj_q.pos1 == i));
        end
    end

    // Index of the corrected data bit, or the check-bit marker for a zero mask.
    always_comb begin
        mask_pos = ERR_POS_CHK;
        for (int i = 0; i < ECC_DATA_W; i++) begin
            if (ecc_res.mask[i]) begin
                mask_pos = INJ_POS_W'(i);
            end
        end
    end

    // Engine sees the stored word while capturing, the write data otherwise.
    assign ecc_data_in   = (state == ST_CAPTURE) ? mem_rdata.data : wdata_q;
    assign ecc_parity_in = mem_rdata.chk;
    assign ecc_bypass    = bypass_q;

    assign mem_en    = (state == ST_ISSUE);
    assign mem_we    = mem_en & ~cmd_rd_q;
    assign mem_addr  = addr_q[AW-1:0];
    assign mem_wdata = '{data: wdata_q ^ flip[ECC_DATA_W-1:0],
                         chk:  ecc_parity_out ^ flip[ECC_CW_W-1:ECC_DATA_W]};

    // A command holds pready low for its first two access cycles.
    a_cmd_waits: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_start |=> !apb_rsp.pready ##1 !apb_rsp.pready ##1 apb_rsp.pready)
        else $error("Command transfer without exactly two wait states.");

    // The master must hold the command transfer while the sequencer runs.
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (state != ST_IDLE) |-> (apb_req.psel && apb_req.penable && apb_req.pwrite &&
                                $stable(apb_req.paddr) && $stable(apb_req.pwdata)))
        else $error("APB request changed during a command.");

    // Distinct H columns leave at most one data bit to correct.
    a_err_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        capture |-> (!(ecc_res.sbit_err && ecc_res.dbit_err) && $onehot0(ecc_res.mask)))
        else $error("Inconsistent error flags or correction mask.");

endmodule

// ==== source/ecc_mem_top.sv ====
`timescale 1ns/100ps

module ecc_mem_top import ecc_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic     clk,
    input  logic     arst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic [ECC_DATA_W-1:0]    ecc_data_in;
    logic [ECC_CHK_W-1:0]     ecc_parity_in;
    logic                     ecc_bypass;
    logic [ECC_CHK_W-1:0]     ecc_parity_out;
    ecc_res_t                 ecc_res;        // Engine outputs, bundled.
    logic                     mem_en;
    logic                     mem_we;
    logic [$clog2(DEPTH)-1:0] mem_addr;
    ecc_cw_t                  mem_wdata;
    ecc_cw_t                  mem_rdata;

    ecc_apb_ctrl #(
        .DEPTH(DEPTH)
    ) u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .ecc_data_in    (ecc_data_in),
        .ecc_parity_in  (ecc_parity_in),
        .ecc_bypass     (ecc_bypass),
        .ecc_res        (ecc_res),
        .ecc_parity_out (ecc_parity_out),
        .mem_en         (mem_en),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata)
    );

    ecc_78_cal u_ecc (
        .data_in    (ecc_data_in),
        .parity_in  (ecc_parity_in),
        .bypass     (ecc_bypass),
        .data_out   (ecc_res.data),
        .parity_out (ecc_parity_out),
        .mask       (ecc_res.mask),
        .sbit_err   (ecc_res.sbit_err),
        .dbit_err   (ecc_res.dbit_err)
    );

    ecc_sram #(
        .DEPTH(DEPTH)
    ) u_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

// ==== source/ecc_pkg.sv ====
package ecc_pkg;

    localparam int ECC_DATA_W = 78;
    localparam int ECC_CHK_W  = 8;
    localparam int ECC_CW_W   = ECC_DATA_W + ECC_CHK_W;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    localparam int CNT_W     = 16;  // Error counters saturate at all ones.
    localparam int INJ_POS_W = 7;
    localparam logic [INJ_POS_W-1:0] ERR_POS_CHK = 7'd127;  // Error sat in a check bit.

    // Register map.
    localparam logic [APB_AW-1:0] REG_CTRL    = 8'h00;
    localparam logic [APB_AW-1:0] REG_ADDR    = 8'h04;
    localparam logic [APB_AW-1:0] REG_WDATA0  = 8'h08;
    localparam logic [APB_AW-1:0] REG_WDATA1  = 8'h0C;
    localparam logic [APB_AW-1:0] REG_WDATA2  = 8'h10;
    localparam logic [APB_AW-1:0] REG_CMD     = 8'h14;
    localparam logic [APB_AW-1:0] REG_RDATA0  = 8'h18;
    localparam logic [APB_AW-1:0] REG_RDATA1  = 8'h1C;
    localparam logic [APB_AW-1:0] REG_RDATA2  = 8'h20;
    localparam logic [APB_AW-1:0] REG_STATUS  = 8'h24;
    localparam logic [APB_AW-1:0] REG_ERR_POS = 8'h28;
    localparam logic [APB_AW-1:0] REG_SBE_CNT = 8'h2C;
    localparam logic [APB_AW-1:0] REG_DBE_CNT = 8'h30;
    localparam logic [APB_AW-1:0] REG_INJ     = 8'h34;

    localparam logic [APB_DW-1:0] CMD_WRITE = 32'd1;
    localparam logic [APB_DW-1:0] CMD_READ  = 32'd2;

    typedef struct packed {
        logic [ECC_DATA_W-1:0] data;
        logic [ECC_CHK_W-1:0]  chk;
    } ecc_cw_t;

    typedef struct packed {
        logic [ECC_DATA_W-1:0] data;
        logic [ECC_DATA_W-1:0] mask;
        logic                  sbit_err;
        logic                  dbit_err;
    } ecc_res_t;

    // Positions 0 to 77 are data bits, 78 to 85 are check bits.
    typedef struct packed {
        logic                 en1;
        logic [INJ_POS_W-1:0] pos1;
        logic                 en0;
        logic [INJ_POS_W-1:0] pos0;
    } ecc_inj_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

// ==== source/ecc_sram.sv ====
`timescale 1ns/100ps

module ecc_sram import ecc_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  ecc_cw_t                  wdata,
    output ecc_cw_t                  rdata
);

    ecc_cw_t mem [DEPTH];

    // Registered read port; rdata keeps the last read word.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    a_addr_range: assert property (@(posedge clk) en |-> (int'(addr) < DEPTH))
        else $error("Array access beyond DEPTH.");

endmodule

// ==== verif/ecc_mem_tb.sv ====
`timescale 1ns/100ps

module ecc_mem_tb import ecc_pkg::*; ();

    localparam int DEPTH      = 16;
    localparam int MAX_CYCLES = 20000;  // Roughly four times the full run.

    logic                  clk;
    logic                  arst_n;
    apb_req_t              req;
    apb_rsp_t              rsp;

    int                    cycles = 0;
    int                    sbe_exp;
    int                    dbe_exp;
    logic [ECC_DATA_W-1:0] words [DEPTH];
    ecc_res_t              exp_q [$];
    ecc_res_t              got_q [$];
    int                    where_q [$];

    ecc_mem_top #(
        .DEPTH(DEPTH)
    ) dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (req),
        .apb_rsp (rsp)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped.");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: the run did not finish in %0d cycles.", MAX_CYCLES));
        end
    end

    task automatic check_word(input logic [APB_DW-1:0] got, input logic [APB_DW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: pslverr of %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_res(input ecc_res_t got, input ecc_res_t exp, input int addr);
        if ((got.sbit_err !== exp.sbit_err) || (got.dbit_err !== exp.dbit_err)) begin
            fail_run($sformatf("CHECK FAILED at %0t: word %0d flags sbit %b dbit %b, expected %b %b",
                               $time, addr, got.sbit_err, got.dbit_err, exp.sbit_err,
                               exp.dbit_err));
        end else if (!exp.dbit_err && (got.data !== exp.data)) begin
            fail_run($sformatf("CHECK FAILED at %0t: word %0d data 0x%0h, expected 0x%0h",
                               $time, addr, got.data, exp.data));
        end else if (got.mask !== exp.mask) begin
            fail_run($sformatf("CHECK FAILED at %0t: word %0d mask 0x%0h, expected 0x%0h",
                               $time, addr, got.mask, exp.mask));
        end
    endtask

    // Expected read result from the written word, the injected flips and bypass.
    function automatic ecc_res_t ref_read(input logic [ECC_DATA_W-1:0] word, input ecc_inj_t inj,
                                          input logic bypass);
        ecc_res_t            res;
        logic [ECC_CW_W-1:0] flips;
        flips = '0;
        if (inj.en0) begin
            flips[inj.pos0] = 1'b1;
        end
        if (inj.en1) begin
            flips[inj.pos1] = 1'b1;
        end
        res      = '0;
        res.data = word;
        if (bypass) begin
            res.data = word ^ flips[ECC_DATA_W-1:0];  // Raw stored data.
        end else if ($countones(flips) == 1) begin
            res.sbit_err = 1'b1;
            res.mask     = flips[ECC_DATA_W-1:0];  // Zero for a check-bit flip.
        end else if ($countones(flips) == 2) begin
            res.dbit_err = 1'b1;
        end
        return res;
    endfunction

    // Logged position of a single flip: the data index, 127 for a check bit.
    function automatic int flip_pos(input ecc_inj_t inj);
        int p;
        p = inj.en0 ? int'(inj.pos0) : int'(inj.pos1);
        return (p < ECC_DATA_W) ? p : 127;
    endfunction

    function automatic logic [ECC_DATA_W-1:0] rand_word();
        return {14'($urandom), $urandom, $urandom};
    endfunction

    // One APB transfer; rsp is sampled at the rising edge that closes each access cycle.
    task automatic apb_transfer(input logic write, input logic [APB_AW-1:0] addr,
                                input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
                                output logic err, output int waits);
        @(negedge clk);
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(negedge clk);
        req.penable = 1'b1;
        waits = 0;
        @(posedge clk);
        while (!rsp.pready) begin
            waits++;
            @(posedge clk);
        end
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        @(negedge clk);
        req.psel    = 1'b0;
        req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err, output int waits);
        logic [APB_DW-1:0] ignored;
        apb_transfer(1'b1, addr, data, ignored, err, waits);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err, output int waits);
        apb_transfer(1'b0, addr, '0, data, err, waits);
    endtask

    task automatic reg_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic err;
        int   waits;
        apb_write(addr, data, err, waits);
        check_err(err, 1'b0, $sformatf("write of offset 0x%0h", addr));
        check_word(APB_DW'(waits), '0, "wait states of a register write");
    endtask

    task automatic reg_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        logic err;
        int   waits;
        apb_read(addr, data, err, waits);
        check_err(err, 1'b0, $sformatf("read of offset 0x%0h", addr));
        check_word(APB_DW'(waits), '0, "wait states of a register read");
    endtask

    task automatic run_cmd(input logic [APB_DW-1:0] code);
        logic err;
        int   waits;
        apb_write(REG_CMD, code, err, waits);
        check_err(err, 1'b0, "memory command");
        check_word(APB_DW'(waits), 32'd2, "wait states of a memory command");
    endtask

    task automatic store_word(input int addr, input logic [ECC_DATA_W-1:0] word,
                              input ecc_inj_t inj);
        logic [APB_DW-1:0] val;
        reg_write(REG_INJ, APB_DW'(inj));
        reg_write(REG_ADDR, APB_DW'(addr));
        reg_write(REG_WDATA0, word[31:0]);
        reg_write(REG_WDATA1, word[63:32]);
        reg_write(REG_WDATA2, APB_DW'(word[ECC_DATA_W-1:64]));
        run_cmd(CMD_WRITE);
        reg_read(REG_INJ, val);
        check_word(val, '0, "INJ after a write command");
    endtask

    // Reads a word back, queues it for the checker, and checks log and counters.
    task automatic load_word(input int addr, input logic [ECC_DATA_W-1:0] word,
                             input ecc_inj_t inj, input logic bypass);
        logic [APB_DW-1:0] d0;
        logic [APB_DW-1:0] d1;
        logic [APB_DW-1:0] d2;
        logic [APB_DW-1:0] st;
        logic [APB_DW-1:0] pos;
        logic [APB_DW-1:0] val;
        ecc_res_t          got;
        ecc_res_t          exp;
        reg_write(REG_ADDR, APB_DW'(addr));
        run_cmd(CMD_READ);
        reg_read(REG_RDATA0, d0);
        reg_read(REG_RDATA1, d1);
        reg_read(REG_RDATA2, d2);
        reg_read(REG_STATUS, st);
        reg_read(REG_ERR_POS, pos);
        got          = '0;
        got.data     = {d2[ECC_DATA_W-65:0], d1, d0};
        got.sbit_err = st[0];
        got.dbit_err = st[1];
        if (st[0] && (pos < ECC_DATA_W)) begin
            got.mask[pos[INJ_POS_W-1:0]] = 1'b1;
        end
        exp = ref_read(word, inj, bypass);
        got_q.push_back(got);
        exp_q.push_back(exp);
        where_q.push_back(addr);
        if (exp.sbit_err) begin
            check_word(pos, APB_DW'(flip_pos(inj)), "ERR_POS");
            sbe_exp++;
        end
        if (exp.dbit_err) begin
            dbe_exp++;
        end
        reg_read(REG_SBE_CNT, val);
        check_word(val, APB_DW'(sbe_exp), "SBE_CNT");
        reg_read(REG_DBE_CNT, val);
        check_word(val, APB_DW'(dbe_exp), "DBE_CNT");
    endtask

    always @(posedge clk) begin
        if (got_q.size() > 0) begin
            check_res(got_q.pop_front(), exp_q.pop_front(), where_q.pop_front());
        end
    end

    initial begin
        logic [APB_DW-1:0]     val;
        logic                  err;
        int                    waits;
        int                    a;
        logic [ECC_DATA_W-1:0] w;
        ecc_inj_t              inj;

        void'($urandom(44));
        clk     = 1'b0;
        arst_n  = 1'b0;
        req     = '0;
        sbe_exp = 0;
        dbe_exp = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        reg_read(REG_STATUS, val);
        check_word(val, '0, "STATUS after reset");
        apb_read(8'h38, val, err, waits);
        check_err(err, 1'b1, "read of an unmapped offset");
        check_word(val, '0, "read data of an unmapped offset");
        check_word(APB_DW'(waits), '0, "wait states of an unmapped read");
        apb_write(8'hFC, 32'h1, err, waits);
        check_err(err, 1'b1, "write of an unmapped offset");

        // Clean round trip over the whole array.
        for (int i = 0; i < DEPTH; i++) begin
            words[i] = rand_word();
            store_word(i, words[i], '0);
        end
        for (int i = 0; i < DEPTH; i++) begin
            load_word(i, words[i], '0, 1'b0);
        end

        for (int n = 0; n < 40; n++) begin
            a        = int'($urandom_range(DEPTH - 1, 0));
            w        = rand_word();
            inj      = '0;
            inj.en0  = 1'b1;
            inj.pos0 = INJ_POS_W'($urandom_range(ECC_CW_W - 1, 0));
            store_word(a, w, inj);
            load_word(a, w, inj, 1'b0);
        end

        for (int n = 0; n < 20; n++) begin
            a        = int'($urandom_range(DEPTH - 1, 0));
            w        = rand_word();
            inj      = '0;
            inj.en0  = 1'b1;
            inj.en1  = 1'b1;
            inj.pos0 = INJ_POS_W'($urandom_range(ECC_CW_W - 1, 0));
            do begin
                inj.pos1 = INJ_POS_W'($urandom_range(ECC_CW_W - 1, 0));
            end while (inj.pos1 == inj.pos0);
            store_word(a, w, inj);
            load_word(a, w, inj, 1'b0);
        end
        reg_write(REG_SBE_CNT, 32'hFFFF_FFFF);  // Any value clears.
        reg_write(REG_DBE_CNT, 32'h0);
        sbe_exp = 0;
        dbe_exp = 0;
        reg_read(REG_SBE_CNT, val);
        check_word(val, '0, "SBE_CNT after clear");
        reg_read(REG_DBE_CNT, val);
        check_word(val, '0, "DBE_CNT after clear");

        reg_write(REG_CTRL, 32'h1);
        reg_read(REG_CTRL, val);
        check_word(val, 32'h1, "CTRL readback");
        for (int n = 0; n < 8; n++) begin
            a        = int'($urandom_range(DEPTH - 1, 0));
            w        = rand_word();
            inj      = '0;
            inj.en0  = 1'b1;
            inj.pos0 = INJ_POS_W'($urandom_range(ECC_DATA_W - 1, 0));
            store_word(a, w, inj);
            load_word(a, w, inj, 1'b1);
        end
        reg_write(REG_CTRL, 32'h0);
        load_word(a, w, inj, 1'b0);  // Same word, corrected this time.

        // Address DEPTH would alias to word 0.
        // Rejected commands must leave that word alone.
        w = rand_word();
        store_word(0, w, '0);
        reg_write(REG_ADDR, APB_DW'(DEPTH));
        reg_write(REG_WDATA0, ~w[31:0]);
        apb_write(REG_CMD, CMD_WRITE, err, waits);
        check_err(err, 1'b1, "write command beyond DEPTH");
        check_word(APB_DW'(waits), '0, "wait states of a rejected command");
        apb_write(REG_CMD, CMD_READ, err, waits);
        check_err(err, 1'b1, "read command beyond DEPTH");
        check_word(APB_DW'(waits), '0, "wait states of a rejected read command");
        reg_write(REG_ADDR, 32'd0);
        apb_write(REG_CMD, 32'd3, err, waits);
        check_err(err, 1'b1, "unknown command code");
        check_word(APB_DW'(waits), '0, "wait states of an unknown command");
        load_word(0, w, '0, 1'b0);

        repeat (2) @(negedge clk);
        if (got_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            fail_run("Some read results were never compared.");
        end
    end

endmodule
